// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --assert --timing
TB_TOP    = cp0Tb
RTL_TOP   = cp0Top
FILELIST  = cp0Top.f
OBJ_DIR   = obj_dir
PASS_MSG  = STATUS: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# The simulation fails unless the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== cp0Top.f ====
+incdir+tb
logic/cp0Pkg.sv
logic/excPkg.sv
logic/cp0Timer.sv
logic/cp0ExcUnit.sv
logic/cp0StatusRegs.sv
logic/cp0Top.sv
tb/cp0Top_props.sv
tb/cp0Tb.sv

// ==== logic/cp0ExcUnit.sv ====
// Exception entry and ERET: Status.EXL, EPC, BadVAddr, Cause.ExcCode and Cause.BD
`timescale 1ns/1ps
`default_nettype none

module cp0ExcUnit import cp0Pkg::*; import excPkg::*; (
    input  wire logic           clk,
    input  wire logic           rstN,
    input  wire logic           wrEn,
    input  wire regNum          wrReg,
    input  wire word            wrData,
    input  wire excPkg::excKind excKind,
    input  wire word            excPc,
    input  wire word            excBadAddr,
    input  wire logic           inDelaySlot,
    output logic                exl,
    output word                 epc,
    output word                 badVAddr,
    output excCode              excCodeReg,
    output logic                branchDelay
);

    logic excEvent;     // Any CP0-visible event, ERET included
    logic isEret;
    logic excTaken;     // A real exception entry
    logic firstLevel;   // Entry from normal mode, so EPC and BD are captured
    logic wrStatus;
    logic wrEpc;
    word  restartPc;

    assign excEvent   = (excKind != excNone) && (excKind != excRefetch);
    assign isEret     = (excKind == excEret);
    assign excTaken   = excEvent && !isEret;
    assign firstLevel = excTaken && !exl;

    assign wrStatus = wrEn && (wrReg == REG_STATUS);
    assign wrEpc    = wrEn && (wrReg == REG_EPC);

    // Point back at the branch when the faulting instruction sits in its delay slot
    assign restartPc = inDelaySlot ? (excPc - INST_BYTES) : excPc;

    // Status.EXL
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exl <= 1'b0;
        end else if (excEvent) begin
            exl <= !isEret;             // Entry sets, ERET clears
        end else if (wrStatus) begin
            exl <= wrData[STATUS_EXL_BIT];
        end
    end

    // Cause.ExcCode and Cause.BD
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            excCodeReg  <= '0;
            branchDelay <= 1'b0;
        end else begin
            if (excTaken) begin
                excCodeReg <= excCodeOf(excKind);
            end
            if (firstLevel) begin
                branchDelay <= inDelaySlot;
            end
        end
    end

    // EPC keeps the first restart address while EXL is already set
    always_ff @(posedge clk) begin
        if (firstLevel) begin
            epc <= restartPc;
        end else if (wrEpc && !excEvent) begin
            epc <= wrData;
        end
    end

    // BadVAddr is only loaded by address errors
    always_ff @(posedge clk) begin
        case (excKind)
            excAdEL_If:           badVAddr <= excPc;
            excAdEL_Mem, excAdES: badVAddr <= excBadAddr;
            default:              badVAddr <= badVAddr;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cp0Pkg.sv ====
// CP0 register numbers, data-word types, field positions and reset values
`default_nettype none

package cp0Pkg;

    typedef logic [31:0] word;     // Data word on the CP0 read and write ports
    typedef logic [4:0]  regNum;   // CP0 register number (rd field of MTC0/MFC0)
    typedef logic [5:0]  irqVec;   // Hardware interrupt lines IP7..IP2
    typedef logic [7:0]  irqMask;  // Status.IM7_0 and the full Cause.IP7_0 vector

    // Register numbers of the implemented registers
    localparam regNum REG_BADVADDR = 5'd8;
    localparam regNum REG_COUNT    = 5'd9;
    localparam regNum REG_COMPARE  = 5'd11;
    localparam regNum REG_STATUS   = 5'd12;
    localparam regNum REG_CAUSE    = 5'd13;
    localparam regNum REG_EPC      = 5'd14;
    localparam regNum REG_PRID     = 5'd15;

    // Status field positions
    localparam int STATUS_IE_BIT  = 0;
    localparam int STATUS_EXL_BIT = 1;
    localparam int STATUS_IM_LSB  = 8;    // IM7_0 occupies 15:8
    localparam int STATUS_BEV_BIT = 22;

    // Cause field positions
    localparam int CAUSE_EXC_LSB  = 2;    // ExcCode occupies 6:2
    localparam int CAUSE_IP_LSB   = 8;    // IP1_0 at 9:8, IP7_2 above it
    localparam int CAUSE_IP_SW_W  = 2;    // Number of software interrupt bits
    localparam int CAUSE_TI_BIT   = 30;
    localparam int CAUSE_BD_BIT   = 31;

    // Reset and constant values
    localparam word  PRID_VALUE       = 32'h0000_4220;
    localparam logic STATUS_BEV_RESET = 1'b1;
    localparam word  COUNT_RESET      = 32'h0000_0000;
    localparam word  COMPARE_RESET    = 32'hffff_ffff;  // Far from Count so TI stays low

    // Byte distance back to the branch for a delay-slot exception
    localparam word  INST_BYTES       = 32'd4;

endpackage

`default_nettype wire

// ==== logic/cp0StatusRegs.sv ====
// Status and Cause interrupt fields, interrupt sampling, pending logic and read mux
`timescale 1ns/1ps
`default_nettype none

module cp0StatusRegs import cp0Pkg::*; import excPkg::*; (
    input  wire logic   clk,
    input  wire logic   rstN,
    input  wire logic   wrEn,
    input  wire regNum  wrReg,
    input  wire word    wrData,
    input  wire irqVec  hwIrq,
    input  wire logic   timerFlag,
    input  wire logic   exl,
    input  wire word    count,
    input  wire word    compare,
    input  wire word    epc,
    input  wire word    badVAddr,
    input  wire excCode excCodeReg,
    input  wire logic   branchDelay,
    input  wire regNum  rdReg,
    output word         rdData,
    output logic        irqPending
);

    logic   bev;
    irqMask im;
    logic   ie;
    logic [CAUSE_IP_SW_W-1:0] ipSw;   // Cause.IP1_0, software set
    irqVec  ipHw;                     // Cause.IP7_2, sampled lines
    irqVec  hwIrqMerged;
    irqMask ipAll;
    logic   wrStatus;
    logic   wrCause;
    word    statusWord;
    word    causeWord;

    assign wrStatus = wrEn && (wrReg == REG_STATUS);
    assign wrCause  = wrEn && (wrReg == REG_CAUSE);

    // Timer shares the top hardware line
    assign hwIrqMerged = hwIrq | {timerFlag, 5'b0};

    // Status fields owned here, EXL lives in the exception unit
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bev <= STATUS_BEV_RESET;
            im  <= '0;
            ie  <= 1'b0;
        end else if (wrStatus) begin
            bev <= wrData[STATUS_BEV_BIT];
            im  <= wrData[STATUS_IM_LSB +: $bits(irqMask)];
            ie  <= wrData[STATUS_IE_BIT];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ipSw <= '0;
            ipHw <= '0;
        end else begin
            ipHw <= hwIrqMerged;        // One-cycle sample every clock
            if (wrCause) begin
                ipSw <= wrData[CAUSE_IP_LSB +: CAUSE_IP_SW_W];
            end
        end
    end

    assign ipAll      = {ipHw, ipSw};
    assign irqPending = ie && !exl && (|(ipAll & im));

    // Full register images for the read port
    always_comb begin
        statusWord                 = '0;
        statusWord[STATUS_IE_BIT]  = ie;
        statusWord[STATUS_EXL_BIT] = exl;
        statusWord[STATUS_IM_LSB +: $bits(irqMask)] = im;
        statusWord[STATUS_BEV_BIT] = bev;

        causeWord                  = '0;
        causeWord[CAUSE_EXC_LSB +: $bits(excCode)]  = excCodeReg;
        causeWord[CAUSE_IP_LSB +: $bits(irqMask)]   = ipAll;
        causeWord[CAUSE_TI_BIT]    = timerFlag;
        causeWord[CAUSE_BD_BIT]    = branchDelay;
    end

    always_comb begin
        case (rdReg)
            REG_BADVADDR: rdData = badVAddr;
            REG_COUNT:    rdData = count;
            REG_COMPARE:  rdData = compare;
            REG_STATUS:   rdData = statusWord;
            REG_CAUSE:    rdData = causeWord;
            REG_EPC:      rdData = epc;
            REG_PRID:     rdData = PRID_VALUE;
            default:      rdData = '0;   // Unimplemented registers
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cp0Timer.sv ====
// Count register with half-rate divider, Compare register and timer interrupt flag
`timescale 1ns/1ps
`default_nettype none

module cp0Timer import cp0Pkg::*; (
    input  wire logic  clk,
    input  wire logic  rstN,
    input  wire logic  wrEn,
    input  wire regNum wrReg,
    input  wire word   wrData,
    output word        count,
    output word        compare,
    output logic       timerFlag
);

    logic halfTick;     // Count advances when this is set
    logic wrCount;
    logic wrCompare;

    assign wrCount   = wrEn && (wrReg == REG_COUNT);
    assign wrCompare = wrEn && (wrReg == REG_COMPARE);

    // Divider and Count
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            halfTick <= 1'b0;
            count    <= COUNT_RESET;
        end else if (wrCount) begin
            halfTick <= 1'b0;   // Restart the phase with the new value
            count    <= wrData;
        end else begin
            halfTick <= ~halfTick;
            if (halfTick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            compare <= COMPARE_RESET;
        end else if (wrCompare) begin
            compare <= wrData;
        end
    end

    // Sticky until software rewrites Compare
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            timerFlag <= 1'b0;
        end else if (wrCompare) begin
            timerFlag <= 1'b0;          // Acknowledge wins over a match
        end else if (count == compare) begin
            timerFlag <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cp0Top.sv ====
// CP0 top level connecting the timer, the exception unit and the status block
`timescale 1ns/1ps
`default_nettype none

module cp0Top import cp0Pkg::*; import excPkg::*; (
    input  wire logic           clk,
    input  wire logic           rstN,
    input  wire irqVec          hwIrq,
    input  wire logic           wrEn,
    input  wire regNum          wrReg,
    input  wire word            wrData,
    input  wire regNum          rdReg,
    output word                 rdData,
    input  wire excPkg::excKind excKind,
    input  wire word            excPc,
    input  wire word            excBadAddr,
    input  wire logic           inDelaySlot,
    output logic                exl,
    output word                 epc,
    output logic                irqPending
);

    word    count;
    word    compare;
    logic   timerFlag;
    word    badVAddr;
    excCode excCodeReg;
    logic   branchDelay;

    cp0Timer timer_inst (
        .clk       (clk),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .wrReg     (wrReg),
        .wrData    (wrData),
        .count     (count),
        .compare   (compare),
        .timerFlag (timerFlag)
    );

    cp0ExcUnit excUnit_inst (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (wrEn),
        .wrReg       (wrReg),
        .wrData      (wrData),
        .excKind     (excKind),
        .excPc       (excPc),
        .excBadAddr  (excBadAddr),
        .inDelaySlot (inDelaySlot),
        .exl         (exl),
        .epc         (epc),
        .badVAddr    (badVAddr),
        .excCodeReg  (excCodeReg),
        .branchDelay (branchDelay)
    );

    cp0StatusRegs statusRegs_inst (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (wrEn),
        .wrReg       (wrReg),
        .wrData      (wrData),
        .hwIrq       (hwIrq),
        .timerFlag   (timerFlag),
        .exl         (exl),
        .count       (count),
        .compare     (compare),
        .epc         (epc),
        .badVAddr    (badVAddr),
        .excCodeReg  (excCodeReg),
        .branchDelay (branchDelay),
        .rdReg       (rdReg),
        .rdData      (rdData),
        .irqPending  (irqPending)
    );

endmodule

`default_nettype wire

// ==== logic/excPkg.sv ====
// Exception-kind enum, ExcCode values and the kind-to-code mapping function
`default_nettype none

package excPkg;

    // Event reported by the pipeline, one per cycle
    typedef enum logic [4:0] {
        excNone      = 5'd0,
        excInterrupt = 5'd1,
        excAdEL_If   = 5'd2,   // Address error on instruction fetch
        excAdEL_Mem  = 5'd3,   // Address error on load
        excAdES      = 5'd4,   // Address error on store
        excSyscall   = 5'd5,
        excBreak     = 5'd6,
        excReserved  = 5'd7,
        excOverflow  = 5'd8,
        excTrap      = 5'd9,
        excEret      = 5'd10,
        excRefetch   = 5'd11   // Pipeline flush only, no CP0 update
    } excKind;

    typedef logic [4:0] excCode;

    // Architectural ExcCode values
    localparam excCode CODE_INT  = 5'h00;
    localparam excCode CODE_ADEL = 5'h04;
    localparam excCode CODE_ADES = 5'h05;
    localparam excCode CODE_SYS  = 5'h08;
    localparam excCode CODE_BP   = 5'h09;
    localparam excCode CODE_RI   = 5'h0a;
    localparam excCode CODE_OV   = 5'h0c;
    localparam excCode CODE_TR   = 5'h0d;

    function automatic excCode excCodeOf(input excKind kind);
        case (kind)
            excInterrupt:            return CODE_INT;
            excAdEL_If, excAdEL_Mem: return CODE_ADEL;
            excAdES:                 return CODE_ADES;
            excSyscall:              return CODE_SYS;
            excBreak:                return CODE_BP;
            excReserved:             return CODE_RI;
            excOverflow:             return CODE_OV;
            excTrap:                 return CODE_TR;
            default:                 return CODE_INT;  // Non-events never reach Cause
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== tb/cp0Model.svh ====
// Reference model of the CP0 registers: state, write and exception updates, expected values
`ifndef CP0_MODEL_SVH
`define CP0_MODEL_SVH

logic       mIe;
logic       mExl;
logic       mBev;
logic [7:0] mIm;
logic [1:0] mIpSw;        // Software interrupt bits
logic       mBd;
logic [4:0] mCode;
word        mEpc;
word        mBadVAddr;
word        mCompare;

task automatic resetModel();
    mIe       = 1'b0;
    mExl      = 1'b0;
    mBev      = 1'b1;
    mIm       = '0;
    mIpSw     = '0;
    mBd       = 1'b0;
    mCode     = '0;
    mEpc      = '0;
    mBadVAddr = '0;
    mCompare  = 32'hffff_ffff;
endtask

// Only the writable fields of each register
task automatic applyWrite(input regNum r, input word d);
    case (r)
        REG_STATUS: begin
            mIe  = d[0];
            mExl = d[1];
            mIm  = d[15:8];
            mBev = d[22];
        end
        REG_CAUSE:   mIpSw = d[9:8];
        REG_EPC:     mEpc = d;
        REG_COMPARE: mCompare = d;
        default:     ;
    endcase
endtask

// ExcCode table for each exception kind
function automatic logic [4:0] codeForKind(input excKind k);
    case (k)
        excInterrupt:            return 5'd0;
        excAdEL_If, excAdEL_Mem: return 5'd4;
        excAdES:                 return 5'd5;
        excSyscall:              return 5'd8;
        excBreak:                return 5'd9;
        excReserved:             return 5'd10;
        excOverflow:             return 5'd12;
        excTrap:                 return 5'd13;
        default:                 return 5'd0;
    endcase
endfunction

task automatic applyException(input excKind k, input word pc, input word bad, input logic ds);
    if (k == excEret) begin
        mExl = 1'b0;
    end else if (k != excNone && k != excRefetch) begin
        if (!mExl) begin
            mEpc = ds ? pc - 32'd4 : pc;   // Restart at the branch
            mBd  = ds;
        end
        mExl  = 1'b1;
        mCode = codeForKind(k);
        if (k == excAdEL_If) begin
            mBadVAddr = pc;
        end else if (k == excAdEL_Mem || k == excAdES) begin
            mBadVAddr = bad;
        end
    end
endtask

function automatic word statusImage();
    return {9'b0, mBev, 6'b0, mIm, 6'b0, mExl, mIe};
endfunction

// Timer flag is assumed clear here
function automatic logic irqExpected(input irqVec hw);
    return mIe && !mExl && (|({hw, mIpSw} & mIm));
endfunction

`endif

// ==== tb/cp0Tb.sv ====
// CP0 testbench: clock and reset, random stimulus, checker, test sequence and summary
`timescale 1ns/1ps
`default_nettype none

module cp0Tb import cp0Pkg::*; import excPkg::*; ();

    logic   clk;
    logic   rstN;
    irqVec  hwIrq;
    logic   wrEn;
    regNum  wrReg;
    word    wrData;
    regNum  rdReg;
    word    rdData;
    excKind excEvt;
    word    excPc;
    word    excBadAddr;
    logic   inDelaySlot;
    logic   exl;
    word    epc;
    logic   irqPending;
    int     seed;
    int     checks;
    int     errors;

    `include "cp0Model.svh"

    cp0Top cp0Top_inst (.excKind(excEvt), .*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check(input string name, input word got, input word exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic writeReg(input regNum r, input word d);
        @(negedge clk);
        wrEn   = 1'b1;
        wrReg  = r;
        wrData = d;
        applyWrite(r, d);
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic readReg(input regNum r, output word d);
        @(negedge clk);
        rdReg = r;
        #1 d = rdData;      // Combinational read path
    endtask

    // One-cycle exception event
    task automatic raiseExc(input excKind k, input word pc, input word bad, input logic ds);
        @(negedge clk);
        excEvt      = k;
        excPc       = pc;
        excBadAddr  = bad;
        inDelaySlot = ds;
        applyException(k, pc, bad, ds);
        @(negedge clk);
        excEvt = excNone;
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        $display("[DONE] %s: %0d errors", name, errors - errsBefore);
    endtask

    initial begin
        word    r;
        word    v;
        int     n;
        int     startErr;
        int     waitCycles;
        irqVec  hw;
        excKind kind;
        seed        = 32'hda7c_e940;
        checks      = 0;
        errors      = 0;
        rstN        = 1'b0;
        hwIrq       = '0;
        wrEn        = 1'b0;
        wrReg       = '0;
        wrData      = '0;
        rdReg       = '0;
        excEvt      = excNone;
        excPc       = '0;
        excBadAddr  = '0;
        inDelaySlot = 1'b0;
        resetModel();
        repeat (10) @(negedge clk);
        rstN = 1'b1;

        startErr = errors;
        readReg(REG_STATUS, v);
        check("Status", v, 32'h0040_0000);      // BEV only
        readReg(REG_CAUSE, v);
        check("Cause", v, 32'h0);
        readReg(REG_PRID, v);
        check("PRId", v, 32'h0000_4220);
        check("exl", {31'b0, exl}, 32'h0);
        check("irqPending", {31'b0, irqPending}, 32'h0);
        reportTest("reset values", startErr);

        startErr = errors;
        for (int i = 0; i < 8; i++) begin
            writeReg(REG_STATUS, $random(seed));
            readReg(REG_STATUS, v);
            check("Status", v & 32'h0040_ff03, statusImage());
            writeReg(REG_CAUSE, $random(seed));
            readReg(REG_CAUSE, v);
            check("Cause.IP1_0", v & 32'h0000_0300, {22'b0, mIpSw, 8'b0});
            writeReg(REG_EPC, $random(seed));
            readReg(REG_EPC, v);
            check("EPC", v, mEpc);
            writeReg(REG_COMPARE, $random(seed));
            readReg(REG_COMPARE, v);
            check("Compare", v, mCompare);
            writeReg(REG_PRID, $random(seed));  // Read-only
            readReg(REG_PRID, v);
            check("PRId", v, 32'h0000_4220);
            readReg(REG_STATUS, v);
            check("Status after PRId write", v & 32'h0040_ff03, statusImage());
            readReg(REG_EPC, v);
            check("EPC after PRId write", v, mEpc);
        end
        reportTest("register read and write", startErr);

        startErr = errors;
        r = $random(seed);
        n = 3 + int'(r[3:0]);
        v = $random(seed);
        writeReg(REG_COUNT, v);
        repeat (2 * n - 1) @(negedge clk);    // The read adds the last cycle
        readReg(REG_COUNT, r);
        check("Count", r, v + word'(n));
        readReg(REG_COUNT, v);
        writeReg(REG_COMPARE, v + 32'd3);
        waitCycles = 0;
        r = '0;
        while (!r[30] && waitCycles < 64) begin
            readReg(REG_CAUSE, r);
            waitCycles++;
        end
        if (!r[30]) begin
            errors++;
            $display("Timeout: timer flag did not set within 64 cycles of the Compare write");
        end
        readReg(REG_COUNT, v);
        writeReg(REG_COMPARE, v + 32'h8000_0000);   // Far ahead, flag stays clear
        readReg(REG_CAUSE, r);
        check("Cause.TI", {31'b0, r[30]}, 32'h0);
        reportTest("timer", startErr);

        startErr = errors;
        raiseExc(excEret, '0, '0, 1'b0);
        check("exl", {31'b0, exl}, 32'h0);
        for (int i = 0; i < 12; i++) begin
            r = $random(seed);
            kind = excKind'(5'd1 + 5'(r % 32'd9));  // Interrupt through Trap
            v = $random(seed);
            raiseExc(kind, {v[31:2], 2'b00}, $random(seed), r[8]);
            check("exl", {31'b0, exl}, {31'b0, mExl});
            check("EPC", epc, mEpc);
            readReg(REG_CAUSE, v);
            check("Cause.ExcCode", {27'b0, v[6:2]}, {27'b0, mCode});
            check("Cause.BD", {31'b0, v[31]}, {31'b0, mBd});
            if (kind inside {excAdEL_If, excAdEL_Mem, excAdES}) begin
                readReg(REG_BADVADDR, v);
                check("BadVAddr", v, mBadVAddr);
            end
            r = $random(seed);
            raiseExc(excKind'(5'd1 + 5'(r % 32'd9)), $random(seed), $random(seed), r[8]);
            check("EPC nested", epc, mEpc);
            raiseExc(excEret, '0, '0, 1'b0);
            check("exl after ERET", {31'b0, exl}, 32'h0);
        end
        reportTest("exception entry", startErr);

        startErr = errors;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            writeReg(REG_STATUS, {9'b0, 1'b1, 6'b0, r[7:0], 6'b0, i[0], 1'b1});
            writeReg(REG_CAUSE, {22'b0, r[9:8], 8'b0});
            @(negedge clk);
            hw = r[15:10];
            hwIrq = hw;
            @(negedge clk);
            check("irqPending", {31'b0, irqPending}, {31'b0, irqExpected(hw)});
        end
        hwIrq = '0;
        reportTest("interrupts", startErr);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/cp0Top_props.sv ====
// Bound assertions on the CP0 top level: EXL masking, exception entry and the PRId constant
`timescale 1ns/1ps
`default_nettype none

module cp0Top_props import cp0Pkg::*; import excPkg::*; (
    input wire logic           clk,
    input wire logic           rstN,
    input wire excPkg::excKind excKind,
    input wire logic           exl,
    input wire logic           irqPending,
    input wire regNum          rdReg,
    input wire word            rdData
);

    // No interrupt is offered while an exception is being handled
    noIrqInExl: assert property (@(posedge clk) disable iff (!rstN) !(irqPending && exl))
        else $error("irqPending is high while exl is set");

    enterSetsExl: assert property (@(posedge clk) disable iff (!rstN)
        (excKind != excNone && excKind != excRefetch && excKind != excEret) |=> exl)
        else $error("exl did not rise after an exception");

    pridConstant: assert property (@(posedge clk) (rdReg == REG_PRID) |-> (rdData == PRID_VALUE))
        else $error("PRId read returned a wrong value");

endmodule

bind cp0Top cp0Top_props props_inst (
    .clk        (clk),
    .rstN       (rstN),
    .excKind    (excKind),
    .exl        (exl),
    .irqPending (irqPending),
    .rdReg      (rdReg),
    .rdData     (rdData)
);

`default_nettype wire
